//--- Bender.yml
package:
  name: spi_video_ram

sources:
  - files:
      - rtl/vram_pkg.sv
      - rtl/vram_write_fifo.sv
      - rtl/sqi_clock_gen.sv
      - rtl/sqi_shifter.sv
      - rtl/vram_sequencer.sv
      - rtl/display_pixel.sv
      - rtl/spi_video_ram.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/spi_video_ram_assertions.sv
      - sim/tb_spi_video_ram.sv

//--- list.f
rtl/vram_pkg.sv
rtl/vram_write_fifo.sv
rtl/sqi_clock_gen.sv
rtl/sqi_shifter.sv
rtl/vram_sequencer.sv
rtl/display_pixel.sv
rtl/spi_video_ram.sv
sim/tb_clock.sv
sim/spi_video_ram_assertions.sv
sim/tb_spi_video_ram.sv

//--- rtl/display_pixel.sv
module display_pixel
    import vram_pkg::*;
(
    input  spos_t      clks_before_active_i,
    input  logic       display_active_i,
    input  pos_t       display_hpos_i,
    input  pos_t       display_vpos_i,
    input  nibble_t    read_nibble_i,
    output logic       trigger_read_o,
    output sram_addr_t line_addr_o,
    output logic       pixel_out_o
);

    logic     in_line;
    logic     in_col;
    pos_t     row;
    logic [1:0] pix_idx;

    assign in_line = (display_vpos_i >= SCREEN_V_OFFSET) &&
                     (display_vpos_i < SCREEN_V_OFFSET + SCREEN_HEIGHT);
    assign in_col  = (display_hpos_i >= SCREEN_H_OFFSET) &&
                     (display_hpos_i < SCREEN_H_OFFSET + SCREEN_WIDTH);

    // fires a fixed number of clks ahead of the first screen pixel
    assign trigger_read_o = in_line &&
        (clks_before_active_i == spos_t'(CLKS_BEFORE_TRIGGER - SCREEN_H_OFFSET));

    // 64 bytes per screen line
    assign row         = display_vpos_i - pos_t'(SCREEN_V_OFFSET);
    assign line_addr_o = sram_addr_t'({row, 6'b000000});

    // first pixel of a nibble sits in bit 3
    assign pix_idx = ~display_hpos_i[1:0];

    assign pixel_out_o = display_active_i && in_line && in_col && !read_nibble_i[pix_idx];

endmodule

//--- rtl/spi_video_ram.sv
module spi_video_ram
    import vram_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    output logic       initialized_o,
    input  spos_t      clks_before_active_i,
    input  logic       display_active_i,
    input  pos_t       display_hpos_i,
    input  pos_t       display_vpos_i,
    output logic       pixel_out_o,
    input  logic       hack_clk_rise_edge_i,
    input  logic       hack_write_i,
    input  vram_addr_t hack_addr_i,
    input  word_t      hack_data_i,
    output logic       sram_cs_n_o,
    output logic       sram_sck_o,
    output logic       sram_sio_oe_o,
    output nibble_t    sram_sio_o,
    input  nibble_t    sram_sio_i
);

    logic       fifo_pop;
    logic       fifo_full;
    logic       fifo_empty;
    vram_addr_t head_addr;
    word_t      head_data;
    logic       trigger_read;
    sram_addr_t line_addr;
    logic       sck_run;
    logic       sck_slow;
    sck_count_t sck_count;
    logic       sck_rise;
    logic       sck_fall;
    logic       load;
    sram_addr_t load_word;
    logic       quad_mode;
    logic       sample_en;
    nibble_t    read_nibble;

    vram_write_fifo u_write_fifo (
        .clk         (clk),
        .reset       (reset),
        .push_i      (hack_clk_rise_edge_i & hack_write_i),
        .push_addr_i (hack_addr_i),
        .push_data_i (hack_data_i),
        .pop_i       (fifo_pop),
        .head_addr_o (head_addr),
        .head_data_o (head_data),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty)
    );

    vram_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .trigger_read_i (trigger_read),
        .line_addr_i    (line_addr),
        .fifo_empty_i   (fifo_empty),
        .head_addr_i    (head_addr),
        .head_data_i    (head_data),
        .sck_count_i    (sck_count),
        .fifo_pop_o     (fifo_pop),
        .sck_run_o      (sck_run),
        .sck_slow_o     (sck_slow),
        .load_o         (load),
        .load_word_o    (load_word),
        .quad_mode_o    (quad_mode),
        .sample_en_o    (sample_en),
        .sram_cs_n_o    (sram_cs_n_o),
        .sram_sio_oe_o  (sram_sio_oe_o),
        .initialized_o  (initialized_o)
    );

    sqi_clock_gen u_clock_gen (
        .clk         (clk),
        .reset       (reset),
        .run_i       (sck_run),
        .slow_i      (sck_slow),
        .sck_o       (sram_sck_o),
        .sck_count_o (sck_count),
        .sck_rise_o  (sck_rise),
        .sck_fall_o  (sck_fall)
    );

    sqi_shifter u_shifter (
        .clk           (clk),
        .reset         (reset),
        .load_i        (load),
        .load_word_i   (load_word),
        .quad_mode_i   (quad_mode),
        .sck_rise_i    (sck_rise),
        .sck_fall_i    (sck_fall),
        .sample_en_i   (sample_en),
        .sio_i         (sram_sio_i),
        .sio_o         (sram_sio_o),
        .read_nibble_o (read_nibble)
    );

    display_pixel u_display_pixel (
        .clks_before_active_i (clks_before_active_i),
        .display_active_i     (display_active_i),
        .display_hpos_i       (display_hpos_i),
        .display_vpos_i       (display_vpos_i),
        .read_nibble_i        (read_nibble),
        .trigger_read_o       (trigger_read),
        .line_addr_o          (line_addr),
        .pixel_out_o          (pixel_out_o)
    );

endmodule

//--- rtl/sqi_clock_gen.sv
module sqi_clock_gen
    import vram_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       run_i,
    input  logic       slow_i,
    output logic       sck_o,
    output sck_count_t sck_count_o,
    output logic       sck_rise_o,
    output logic       sck_fall_o
);

    logic started;
    logic phase;
    logic toggle;

    // one idle clk after run goes high, so data is set up before the first rise
    // slow mode toggles on every other clk
    assign toggle = started && (!slow_i || !phase);

    always_ff @(posedge clk) begin
        if (reset || !run_i) begin
            started     <= 1'b0;
            phase       <= 1'b0;
            sck_o       <= 1'b0;
            sck_count_o <= '0;
            sck_rise_o  <= 1'b0;
            sck_fall_o  <= 1'b0;
        end else begin
            started    <= 1'b1;
            sck_rise_o <= toggle && !sck_o;
            sck_fall_o <= toggle && sck_o;
            if (started) begin
                phase <= !phase;
            end
            if (toggle) begin
                sck_o <= !sck_o;
            end
            // count serial clock rises of this transaction
            if (toggle && !sck_o) begin
                sck_count_o <= sck_count_o + 1'b1;
            end
        end
    end

endmodule

//--- rtl/sqi_shifter.sv
module sqi_shifter
    import vram_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load_i,
    input  sram_addr_t load_word_i,
    input  logic       quad_mode_i,
    input  logic       sck_rise_i,
    input  logic       sck_fall_i,
    input  logic       sample_en_i,
    input  nibble_t    sio_i,
    output nibble_t    sio_o,
    output nibble_t    read_nibble_o
);

    // low nibble stays zero so an exhausted buffer sends zeros
    logic [SHIFT_WIDTH-1:0] out_buf;
    buf_idx_t               bit_idx;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_buf <= '0;
            bit_idx <= buf_idx_t'(3);
        end else begin
            if (sck_rise_i && bit_idx > buf_idx_t'(3)) begin
                if (quad_mode_i) begin
                    bit_idx <= bit_idx - buf_idx_t'(4);
                end else begin
                    bit_idx <= bit_idx - buf_idx_t'(1);
                end
            end
            // a new phase overrides the shift on the same clk
            if (load_i) begin
                out_buf <= {load_word_i, 4'b0000};
                bit_idx <= buf_idx_t'(SHIFT_WIDTH - 1);
            end
        end
    end

    always_comb begin
        if (quad_mode_i) begin
            sio_o = out_buf[bit_idx -: 4];
        end else begin
            // spi mode, hold_n on sio3 kept high
            sio_o = {1'b1, 2'b00, out_buf[bit_idx]};
        end
    end

    // sram drives data on the falling edge
    always_ff @(posedge clk) begin
        if (sck_fall_i && sample_en_i) begin
            read_nibble_o <= sio_i;
        end
    end

endmodule

//--- rtl/vram_pkg.sv
package vram_pkg;

    // data widths
    localparam int WORD_WIDTH      = 16;
    localparam int VRAM_ADDR_WIDTH = 13;
    localparam int SRAM_ADDR_WIDTH = 24;
    localparam int INSTR_WIDTH     = 8;

    // output buffer plus one spare nibble of zeros
    localparam int SHIFT_WIDTH = SRAM_ADDR_WIDTH + 4;

    localparam int FIFO_DEPTH = 8;

    typedef logic [WORD_WIDTH-1:0]          word_t;
    typedef logic [VRAM_ADDR_WIDTH-1:0]     vram_addr_t;
    typedef logic [SRAM_ADDR_WIDTH-1:0]     sram_addr_t;
    typedef logic [3:0]                     nibble_t;
    typedef logic [7:0]                     sck_count_t;
    typedef logic [9:0]                     pos_t;
    typedef logic signed [9:0]              spos_t;
    typedef logic [$clog2(SHIFT_WIDTH)-1:0] buf_idx_t;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_SET_QUAD,
        ST_IDLE,
        ST_READ,
        ST_WRITE
    } vram_state_e;

    // screen geometry inside the display raster
    localparam int SCREEN_WIDTH     = 512;
    localparam int SCREEN_HEIGHT    = 256;
    localparam int SCREEN_H_OFFSET  = 64;
    localparam int SCREEN_V_OFFSET  = 112;
    localparam int NIBBLES_PER_LINE = SCREEN_WIDTH / 4;

    localparam int CLKS_BEFORE_TRIGGER = 46;

    // 23LC1024 commands
    localparam logic [INSTR_WIDTH-1:0] INS_READ  = 8'h03;
    localparam logic [INSTR_WIDTH-1:0] INS_WRITE = 8'h02;
    localparam logic [INSTR_WIDTH-1:0] INS_EQIO  = 8'h38;
    localparam logic [INSTR_WIDTH-1:0] INS_RSTIO = 8'hFF;

    // serial clocks per transfer phase
    localparam sck_count_t INSTR_SCK = 8'd2;
    localparam sck_count_t ADDR_SCK  = 8'd6;
    localparam sck_count_t DUMMY_SCK = 8'd2;
    localparam sck_count_t WORD_SCK  = 8'd4;

    localparam sck_count_t READ_LINE_SCK =
        INSTR_SCK + ADDR_SCK + DUMMY_SCK + sck_count_t'(NIBBLES_PER_LINE) + 8'd1;
    localparam sck_count_t WRITE_WORD_SCK  = INSTR_SCK + ADDR_SCK + WORD_SCK;
    localparam sck_count_t EQIO_SCK        = 8'd8;
    localparam sck_count_t RSTIO_SCK       = 8'd2;
    localparam sck_count_t SAMPLE_FROM_SCK = INSTR_SCK + ADDR_SCK + DUMMY_SCK;

endpackage

//--- rtl/vram_sequencer.sv
module vram_sequencer
    import vram_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       trigger_read_i,
    input  sram_addr_t line_addr_i,
    input  logic       fifo_empty_i,
    input  vram_addr_t head_addr_i,
    input  word_t      head_data_i,
    input  sck_count_t sck_count_i,
    output logic       fifo_pop_o,
    output logic       sck_run_o,
    output logic       sck_slow_o,
    output logic       load_o,
    output sram_addr_t load_word_o,
    output logic       quad_mode_o,
    output logic       sample_en_o,
    output logic       sram_cs_n_o,
    output logic       sram_sio_oe_o,
    output logic       initialized_o
);

    vram_state_e state;
    logic        read_pending;
    vram_addr_t  wr_addr;
    word_t       wr_data;
    word_t       data_rev;
    sck_count_t  last_count;
    logic        at_boundary;

    assign sck_run_o   = (state != ST_IDLE);
    assign sck_slow_o  = (state == ST_READ);
    assign quad_mode_o = (state != ST_SET_QUAD);
    assign sample_en_o = (state == ST_READ) && (sck_count_i >= SAMPLE_FROM_SCK);

    // reads only start on an empty fifo, so a waiting word always means write
    assign fifo_pop_o = (state == ST_IDLE) && initialized_o && !fifo_empty_i;

    // one load per phase, on the first clk its count is seen
    assign load_o = at_boundary && (sck_count_i != last_count);

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= ST_RESET;
            initialized_o <= 1'b0;
            read_pending  <= 1'b0;
        end else begin
            case (state)
                ST_RESET: begin
                    if (sck_count_i == RSTIO_SCK) begin
                        state <= ST_IDLE;
                    end
                end
                ST_SET_QUAD: begin
                    if (sck_count_i == EQIO_SCK) begin
                        state         <= ST_IDLE;
                        initialized_o <= 1'b1;
                    end
                end
                ST_IDLE: begin
                    if (trigger_read_i) begin
                        read_pending <= 1'b1;
                    end
                    if (!initialized_o) begin
                        state <= ST_SET_QUAD;
                    end else if (fifo_empty_i && read_pending) begin
                        state        <= ST_READ;
                        read_pending <= 1'b0;
                    end else if (!fifo_empty_i) begin
                        state <= ST_WRITE;
                    end
                end
                ST_READ: begin
                    if (sck_count_i == READ_LINE_SCK) begin
                        state <= ST_IDLE;
                    end
                end
                ST_WRITE: begin
                    if (sck_count_i == WRITE_WORD_SCK) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // hold the popped word for the whole write
    always_ff @(posedge clk) begin
        if (fifo_pop_o) begin
            wr_addr <= head_addr_i;
            wr_data <= head_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || state == ST_IDLE) begin
            last_count <= '1;
        end else begin
            last_count <= sck_count_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sram_cs_n_o   <= 1'b1;
            sram_sio_oe_o <= 1'b1;
        end else begin
            sram_cs_n_o   <= (state == ST_IDLE);
            sram_sio_oe_o <= !sample_en_o;
        end
    end

    always_comb begin
        at_boundary = 1'b0;
        load_word_o = '0;
        // screen expects the first pixel in bit 0
        data_rev    = {<<{wr_data}};
        case (state)
            ST_RESET: begin
                if (sck_count_i == '0) begin
                    at_boundary = 1'b1;
                    load_word_o = {INS_RSTIO, {(SRAM_ADDR_WIDTH - INSTR_WIDTH){1'b0}}};
                end
            end
            ST_SET_QUAD: begin
                if (sck_count_i == '0) begin
                    at_boundary = 1'b1;
                    load_word_o = {INS_EQIO, {(SRAM_ADDR_WIDTH - INSTR_WIDTH){1'b0}}};
                end
            end
            ST_READ: begin
                if (sck_count_i == '0) begin
                    at_boundary = 1'b1;
                    load_word_o = {INS_READ, {(SRAM_ADDR_WIDTH - INSTR_WIDTH){1'b0}}};
                end else if (sck_count_i == INSTR_SCK) begin
                    at_boundary = 1'b1;
                    load_word_o = line_addr_i;
                end
            end
            ST_WRITE: begin
                if (sck_count_i == '0) begin
                    at_boundary = 1'b1;
                    load_word_o = {INS_WRITE, {(SRAM_ADDR_WIDTH - INSTR_WIDTH){1'b0}}};
                end else if (sck_count_i == INSTR_SCK) begin
                    // two sram bytes per cpu word
                    at_boundary = 1'b1;
                    load_word_o = sram_addr_t'({wr_addr, 1'b0});
                end else if (sck_count_i == INSTR_SCK + ADDR_SCK) begin
                    at_boundary = 1'b1;
                    load_word_o = {data_rev, {(SRAM_ADDR_WIDTH - WORD_WIDTH){1'b0}}};
                end
            end
            default: begin
                at_boundary = 1'b0;
            end
        endcase
    end

endmodule

//--- rtl/vram_write_fifo.sv
module vram_write_fifo
    import vram_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       push_i,
    input  vram_addr_t push_addr_i,
    input  word_t      push_data_i,
    input  logic       pop_i,
    output vram_addr_t head_addr_o,
    output word_t      head_data_o,
    output logic       full_o,
    output logic       empty_o
);

    vram_addr_t addr_mem [FIFO_DEPTH];
    word_t      data_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   count;
    logic                          push_ok;
    logic                          pop_ok;

    // a write offered while full is simply lost
    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    assign full_o      = (count == FIFO_DEPTH);
    assign empty_o     = (count == '0);
    assign head_addr_o = addr_mem[rd_ptr];
    assign head_data_o = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok) begin
            addr_mem[wr_ptr] <= push_addr_i;
            data_mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- sim/spi_video_ram_assertions.sv
module spi_video_ram_assertions
    import vram_pkg::*;
(
    input logic       clk_i,
    input logic       reset_i,
    input logic       cs_n_i,
    input logic       sck_i,
    input logic       oe_i,
    input nibble_t    sio_out_i,
    input nibble_t    sio_in_i,
    input logic       initialized_i,
    input logic       pixel_i,
    input spos_t      clks_before_active_i,
    input logic       display_active_i,
    input pos_t       hpos_i,
    input pos_t       vpos_i,
    input logic       strobe_i,
    input logic       write_i,
    input vram_addr_t addr_i,
    input word_t      data_i
);

    int          fail_cnt = 0;
    int          pending_cnt = 0;
    int          txn_idx;
    int          rise_cnt;
    logic        sck_q;
    logic        cs_n_q;
    logic [7:0]  cmd;
    logic [7:0]  spi_log;
    logic [47:0] nib_log;
    logic        sio3_low;
    logic        in_read;
    logic        have_nib;
    nibble_t     exp_nib;
    sram_addr_t  exp_line;
    logic [28:0] pending [$];
    logic [28:0] head_q;
    word_t       rev;
    logic [47:0] exp_write;
    logic        in_line;
    logic        in_col;
    logic        exp_pixel;

    assign in_line = (vpos_i >= SCREEN_V_OFFSET) && (vpos_i < SCREEN_V_OFFSET + SCREEN_HEIGHT);
    assign in_col  = (hpos_i >= SCREEN_H_OFFSET) && (hpos_i < SCREEN_H_OFFSET + SCREEN_WIDTH);
    assign exp_pixel = display_active_i && in_line && in_col && !exp_nib[3 - hpos_i[1:0]];

    // command, doubled word address, data with bit 0 sent first
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            rev[i] = head_q[15 - i];
        end
        exp_write = {8'h02, sram_addr_t'({head_q[28:16], 1'b0}), rev};
    end

    always_ff @(posedge clk_i) begin
        sck_q  <= sck_i;
        cs_n_q <= cs_n_i;
        if (reset_i) begin
            txn_idx  <= 0;
            rise_cnt <= 0;
            in_read  <= 1'b0;
            have_nib <= 1'b0;
            pending.delete();
        end else begin
            if (cs_n_i) begin
                rise_cnt <= 0;
                cmd      <= '0;
                spi_log  <= '0;
                sio3_low <= 1'b0;
                in_read  <= 1'b0;
                // end of a chip select low period
                if (!cs_n_q) begin
                    txn_idx  <= txn_idx + 1;
                    have_nib <= have_nib || in_read;
                    if (cmd == 8'h02 && pending.size() > 0) begin
                        pending.pop_front();
                    end
                end
            end else if (sck_i && !sck_q) begin
                rise_cnt <= rise_cnt + 1;
                if (rise_cnt < 2) begin
                    cmd <= {cmd[3:0], sio_out_i};
                end
                if (rise_cnt == 1 && {cmd[3:0], sio_out_i} == 8'h03) begin
                    in_read <= 1'b1;
                end
                if (rise_cnt < 12) begin
                    nib_log <= {nib_log[43:0], sio_out_i};
                end
                spi_log <= {spi_log[6:0], sio_out_i[0]};
                if (!sio_out_i[3]) begin
                    sio3_low <= 1'b1;
                end
            end
            if (in_read && rise_cnt >= 11) begin
                exp_nib <= sio_in_i;
            end
            if (in_line && clks_before_active_i == spos_t'(CLKS_BEFORE_TRIGGER - SCREEN_H_OFFSET)) begin
                exp_line <= sram_addr_t'((int'(vpos_i) - SCREEN_V_OFFSET) * 64);
            end
            // cpu write accepted unless eight are already waiting
            if (strobe_i && write_i && pending.size() < FIFO_DEPTH) begin
                pending.push_back({addr_i, data_i});
            end
        end
        head_q      <= (pending.size() > 0) ? pending[0] : '0;
        pending_cnt <= pending.size();
    end

    a_reset: assert property (@(posedge clk_i) reset_i |=> cs_n_i && !initialized_i && oe_i)
        else begin fail_cnt++; $error("Mismatch at %0t: outputs wrong after reset", $time); end

    a_init_order: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(initialized_i) |-> txn_idx == 1 && !cs_n_i)
        else begin fail_cnt++; $error("Mismatch at %0t: initialized out of order", $time); end

    a_rstio: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(cs_n_i) && txn_idx == 0 |-> rise_cnt == 2 && cmd == 8'hFF && !initialized_i)
        else begin fail_cnt++; $error("Mismatch at %0t: reset-I/O transfer wrong", $time); end

    a_eqio: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(cs_n_i) && txn_idx == 1 |-> rise_cnt == 8 && spi_log == 8'h38 && !sio3_low)
        else begin fail_cnt++; $error("Mismatch at %0t: enter-quad transfer wrong", $time); end

    a_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(cs_n_i) && txn_idx >= 2 |-> cmd == 8'h02 || cmd == 8'h03)
        else begin fail_cnt++; $error("Mismatch at %0t: unknown command %h", $time, cmd); end

    a_write: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(cs_n_i) && txn_idx >= 2 && cmd == 8'h02 |->
            rise_cnt == 12 && pending_cnt > 0 && nib_log == exp_write)
        else begin fail_cnt++; $error("Mismatch at %0t: write sent %h", $time, nib_log); end

    a_read: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(cs_n_i) && txn_idx >= 2 && cmd == 8'h03 |->
            rise_cnt == 139 && nib_log[39:16] == exp_line && oe_i)
        else begin fail_cnt++; $error("Mismatch at %0t: line read wrong", $time); end

    a_oe_low: assert property (@(posedge clk_i) disable iff (reset_i)
        !oe_i |-> in_read && rise_cnt >= 10)
        else begin fail_cnt++; $error("Mismatch at %0t: output enable low too early", $time); end

    a_oe_off: assert property (@(posedge clk_i) disable iff (reset_i)
        in_read && !cs_n_i && rise_cnt >= 11 |-> !oe_i)
        else begin fail_cnt++; $error("Mismatch at %0t: output enable still high", $time); end

    a_pixel: assert property (@(posedge clk_i) disable iff (reset_i)
        have_nib && !in_read |-> pixel_i == exp_pixel)
        else begin fail_cnt++; $error("Mismatch at %0t: pixel at hpos %0d", $time, hpos_i); end

endmodule

bind spi_video_ram spi_video_ram_assertions u_assertions (
    .clk_i                (clk),
    .reset_i              (reset),
    .cs_n_i               (sram_cs_n_o),
    .sck_i                (sram_sck_o),
    .oe_i                 (sram_sio_oe_o),
    .sio_out_i            (sram_sio_o),
    .sio_in_i             (sram_sio_i),
    .initialized_i        (initialized_o),
    .pixel_i              (pixel_out_o),
    .clks_before_active_i (clks_before_active_i),
    .display_active_i     (display_active_i),
    .hpos_i               (display_hpos_i),
    .vpos_i               (display_vpos_i),
    .strobe_i             (hack_clk_rise_edge_i),
    .write_i              (hack_write_i),
    .addr_i               (hack_addr_i),
    .data_i               (hack_data_i)
);

//--- sim/tb_clock.sv
module tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // reset held over the first three rising edges
    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

//--- sim/tb_spi_video_ram.sv
module tb_spi_video_ram
    import vram_pkg::*;
;

    localparam int READ_CLKS  = 4 * READ_LINE_SCK + 8;
    localparam int WRITE_CLKS = 2 * WRITE_WORD_SCK + 6;
    localparam int INIT_CLKS  = 2 * (RSTIO_SCK + EQIO_SCK) + 10;
    // six line reads, forty word writes and the init sequence, doubled
    localparam int TIMEOUT_CYCLES = 2 * (6 * READ_CLKS + 40 * WRITE_CLKS + INIT_CLKS);

    logic       clk;
    logic       reset;
    logic       initialized;
    spos_t      clks_before_active;
    logic       display_active;
    pos_t       hpos;
    pos_t       vpos;
    logic       pixel_out;
    logic       cpu_strobe;
    logic       cpu_write;
    vram_addr_t cpu_addr;
    word_t      cpu_data;
    logic       cs_n;
    logic       sck;
    logic       sio_oe;
    nibble_t    sio_out;
    nibble_t    sio_in;

    int   errors = 0;
    int   cycles = 0;
    int   txn_cnt = 0;
    int   exp_txn = 0;
    logic cs_q = 1'b1;

    tb_clock u_clock (
        .clk_o   (clk),
        .reset_o (reset)
    );

    spi_video_ram DUT (
        .clk                  (clk),
        .reset                (reset),
        .initialized_o        (initialized),
        .clks_before_active_i (clks_before_active),
        .display_active_i     (display_active),
        .display_hpos_i       (hpos),
        .display_vpos_i       (vpos),
        .pixel_out_o          (pixel_out),
        .hack_clk_rise_edge_i (cpu_strobe),
        .hack_write_i         (cpu_write),
        .hack_addr_i          (cpu_addr),
        .hack_data_i          (cpu_data),
        .sram_cs_n_o          (cs_n),
        .sram_sck_o           (sck),
        .sram_sio_oe_o        (sio_oe),
        .sram_sio_o           (sio_out),
        .sram_sio_i           (sio_in)
    );

    // chip select falls counted as transactions
    always @(posedge clk) begin
        cycles <= cycles + 1;
        cs_q   <= cs_n;
        if (!reset && cs_q && !cs_n) begin
            txn_cnt <= txn_cnt + 1;
        end
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Timeout: SRAM transactions did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    task automatic wait_idle();
        while (!cs_n) @(posedge clk);
    endtask

    task automatic wait_txn();
        while (cs_n) @(posedge clk);
        wait_idle();
    endtask

    task automatic offer_cpu(input logic strobe, input logic write);
        @(posedge clk);
        cpu_strobe <= strobe;
        cpu_write  <= write;
        cpu_addr   <= vram_addr_t'($urandom);
        cpu_data   <= word_t'($urandom);
        @(posedge clk);
        cpu_strobe <= 1'b0;
        cpu_write  <= 1'b0;
    endtask

    task automatic sweep_pixels(input int first, input int last, input logic active);
        int h;
        for (h = first; h <= last; h++) begin
            @(posedge clk);
            hpos           <= pos_t'(h);
            display_active <= active;
        end
    endtask

    // shortened raster: trigger, line read, then a few pixel runs
    task automatic show_line(input int row, input int burst);
        int k;
        int accepted;
        @(posedge clk);
        display_active <= 1'b0;
        vpos           <= pos_t'(SCREEN_V_OFFSET + row);
        sio_in         <= nibble_t'($urandom);
        for (k = 2; k >= -1; k--) begin
            @(posedge clk);
            clks_before_active <= spos_t'(CLKS_BEFORE_TRIGGER - SCREEN_H_OFFSET + k);
        end
        @(posedge clk);
        clks_before_active <= '0;
        while (cs_n) @(posedge clk);
        for (k = 0; k < burst; k++) begin
            @(posedge clk);
            cpu_strobe <= 1'b1;
            cpu_write  <= 1'b1;
            cpu_addr   <= vram_addr_t'($urandom);
            cpu_data   <= word_t'($urandom);
        end
        @(posedge clk);
        cpu_strobe <= 1'b0;
        cpu_write  <= 1'b0;
        wait_idle();
        accepted = (burst > FIFO_DEPTH) ? FIFO_DEPTH : burst;
        repeat (accepted) wait_txn();
        exp_txn = exp_txn + 1 + accepted;
        sweep_pixels(58, 69, 1'b1);
        sweep_pixels(300, 303, 1'b0);
        sweep_pixels(400, 407, 1'b1);
        sweep_pixels(570, 581, 1'b1);
        @(posedge clk);
        vpos <= pos_t'(SCREEN_V_OFFSET - 1);
        sweep_pixels(64, 71, 1'b1);
    endtask

    initial begin
        void'($urandom(32'h4c5d_e575));
        clks_before_active <= '0;
        display_active     <= 1'b0;
        hpos               <= '0;
        vpos               <= '0;
        cpu_strobe         <= 1'b0;
        cpu_write          <= 1'b0;
        cpu_addr           <= '0;
        cpu_data           <= '0;
        sio_in             <= '0;
        while (reset) @(posedge clk);
        while (!initialized) @(posedge clk);
        wait_idle();
        exp_txn = 2;

        repeat (20) begin
            offer_cpu(1'b1, 1'b1);
            wait_txn();
            exp_txn++;
        end
        // neither of these is a write
        offer_cpu(1'b1, 1'b0);
        offer_cpu(1'b0, 1'b1);
        repeat (20) @(posedge clk);

        show_line(0, 0);
        show_line(SCREEN_HEIGHT - 1, 0);
        repeat (3) show_line($urandom_range(SCREEN_HEIGHT - 1), 0);
        show_line($urandom_range(SCREEN_HEIGHT - 1), FIFO_DEPTH + 4);
        repeat (40) @(posedge clk);

        if (txn_cnt != exp_txn) begin
            $display("Mismatch at %0t: %0d transactions seen, %0d expected", $time, txn_cnt, exp_txn);
            errors++;
        end
        if (DUT.u_assertions.pending_cnt != 0) begin
            $display("Mismatch at %0t: %0d accepted writes never sent", $time,
                     DUT.u_assertions.pending_cnt);
            errors++;
        end
        $display("Assertion failures: %0d, mismatches: %0d", DUT.u_assertions.fail_cnt, errors);
        if (DUT.u_assertions.fail_cnt == 0 && errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
